//--- zx_mem_map_pkg.sv
`default_nettype none

package zx_mem_map_pkg;

	// ==============================
	// Address widths
	// ==============================

	// External RAM space, byte addressed
	localparam int ram_addr_w = 25;
	localparam int cpu_addr_w = 16;
	// Offset inside one 16K bank
	localparam int bank_off_w = 14;
	// Top CPU address bits pick one of four banks
	localparam int bank_sel_w = cpu_addr_w - bank_off_w;

	localparam int ram_page_w = 6;
	localparam int rom_page_w = 4;
	// Page bits above the three 7FFD bank bits
	localparam int ext_page_w = ram_page_w - 3;

	// ==============================
	// Fixed layout
	// ==============================

	// ROM pages live above all RAM pages
	localparam logic [2:0] rom_base = 3'd5;
	localparam int rom_span_w = 3 + rom_page_w + bank_off_w;
	// Everything below this bit is paged RAM
	localparam int ram_span_w = ram_page_w + bank_off_w;

	// Banks at 4000 and 8000 in normal mode
	localparam logic [2:0] bank_screen0 = 3'd5;
	localparam logic [2:0] bank_fixed_8000 = 3'd2;

	// Same order as the memory menu
	typedef enum logic [2:0] {
		model_128k = 3'd0,
		model_p1024 = 3'd1,
		model_profi = 3'd2,
		model_48k = 3'd3,
		model_plus3 = 3'd4
	} model_t;

endpackage

`default_nettype wire

//--- zx_port_map_pkg.sv
`default_nettype none

package zx_port_map_pkg;

	// CPU data bus and paging register width
	localparam int data_w = 8;

	// ==============================
	// Port decode
	// ==============================

	// Profi extension port, full decode
	localparam logic [15:0] port_dffd = 16'hDFFD;

	// Partial decode address bits
	localparam int a7ffd_a15 = 15;
	localparam int a7ffd_a14 = 14;
	localparam int a7ffd_a1 = 1;
	localparam int a1ffd_a12 = 12;
	localparam int a1ffd_a13 = 13;
	localparam int aeff7_a3 = 3;

	// ==============================
	// Register bits
	// ==============================

	// 7FFD
	localparam int reg7_scr = 3;
	localparam int reg7_rom = 4;
	localparam int reg7_lock = 5;

	// 1FFD (+3 only)
	localparam int reg1_special = 0;
	localparam int reg1_rom = 2;
	localparam int reg1_motor = 3;

	// EFF7 (Pentagon 1024)
	localparam int eff7_lockext = 2;

endpackage

`default_nettype wire

//--- zx_port_decode.sv
`timescale 1ns/1ps
`default_nettype none

module zx_port_decode (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic io_wr,
	input wire logic [zx_mem_map_pkg::cpu_addr_w-1:0] addr,
	input wire logic page_disable,
	input wire logic plus3,
	input wire logic p1024,
	input wire logic profi,
	output logic wr_7ffd,
	output logic wr_1ffd,
	output logic wr_eff7,
	output logic wr_dffd
);

	logic io_wr_q;
	logic io_wr_rise;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_eff7;
	logic hit_dffd;

	// Previous io_wr level for edge detect
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// First cycle of an I/O write only
	assign io_wr_rise = io_wr & ~io_wr_q;

	// ==============================
	// Address decode
	// ==============================

	// 7FFD ignores A14 except on the +3
	assign hit_7ffd = ~addr[zx_port_map_pkg::a7ffd_a15] & ~addr[zx_port_map_pkg::a7ffd_a1]
		& (addr[zx_port_map_pkg::a7ffd_a14] | ~plus3) & ~page_disable;

	// 1FFD shares the lock with 7FFD
	assign hit_1ffd = plus3 & ~page_disable
		& ~addr[zx_port_map_pkg::a7ffd_a1]
		& addr[zx_port_map_pkg::a1ffd_a12]
		& ~addr[zx_port_map_pkg::a1ffd_a13]
		& ~addr[zx_port_map_pkg::a7ffd_a14]
		& ~addr[zx_port_map_pkg::a7ffd_a15];

	// EFF7 stays writable after the 7FFD lock
	assign hit_eff7 = p1024
		& addr[zx_port_map_pkg::a7ffd_a15]
		& addr[zx_port_map_pkg::a7ffd_a14]
		& addr[zx_port_map_pkg::a1ffd_a13]
		& ~addr[zx_port_map_pkg::a1ffd_a12]
		& ~addr[zx_port_map_pkg::aeff7_a3];

	assign hit_dffd = profi & (addr == zx_port_map_pkg::port_dffd);

	assign wr_7ffd = io_wr_rise & hit_7ffd;
	assign wr_1ffd = io_wr_rise & hit_1ffd;
	assign wr_eff7 = io_wr_rise & hit_eff7;
	assign wr_dffd = io_wr_rise & hit_dffd;

	// Decode terms assume at most one machine flag
	assert property (@(posedge clk_sys) disable iff (reset) $onehot0({plus3, p1024, profi}))
		else $error("More than one machine flag set in the port decode");

endmodule

`default_nettype wire

//--- zx_page_regs.sv
`timescale 1ns/1ps
`default_nettype none

module zx_page_regs (
	input wire logic clk_sys,
	input wire logic reset,
	input wire zx_mem_map_pkg::model_t model,
	input wire logic [zx_port_map_pkg::data_w-1:0] data_in,
	input wire logic wr_7ffd,
	input wire logic wr_1ffd,
	input wire logic wr_eff7,
	input wire logic wr_dffd,
	output logic [zx_port_map_pkg::data_w-1:0] page_reg,
	output logic [zx_port_map_pkg::data_w-1:0] page_reg_plus3,
	output logic [zx_mem_map_pkg::ext_page_w-1:0] page_128k,
	output logic zx48,
	output logic plus3,
	output logic p1024,
	output logic profi,
	output logic page_disable,
	output logic screen_page,
	output logic motor
);

	logic [zx_port_map_pkg::data_w-1:0] page_reg_eff7;

	// ==============================
	// Model flags
	// ==============================

	// Latched while reset is held, stable afterwards
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48 <= (model == zx_mem_map_pkg::model_48k);
			plus3 <= (model == zx_mem_map_pkg::model_plus3);
			p1024 <= (model == zx_mem_map_pkg::model_p1024);
			profi <= (model == zx_mem_map_pkg::model_profi);
		end
	end

	// ==============================
	// Paging registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg <= '0;
			page_reg_plus3 <= '0;
			page_reg_eff7 <= '0;
			page_128k <= '0;
			screen_page <= 1'b0;
		end else begin
			if (wr_7ffd) begin
				page_reg <= data_in;
				screen_page <= data_in[zx_port_map_pkg::reg7_scr];
				// Pentagon 1024 extension bits, unless frozen by EFF7
				if (p1024 && !page_reg_eff7[zx_port_map_pkg::eff7_lockext]) begin
					page_128k <= {data_in[5], data_in[7:6]};
				end
			end

			if (wr_1ffd) begin
				page_reg_plus3 <= data_in;
			end

			if (wr_eff7) begin
				page_reg_eff7 <= data_in;
			end

			// Profi keeps the upper page bits in a separate port
			if (wr_dffd) begin
				page_128k <= data_in[zx_mem_map_pkg::ext_page_w-1:0];
			end
		end
	end

	// Lock rule
	// 48K is always locked, Pentagon 1024 needs EFF7 bit 2 as well
	assign page_disable = zx48
		| (~p1024 & page_reg[zx_port_map_pkg::reg7_lock])
		| (p1024 & page_reg_eff7[zx_port_map_pkg::eff7_lockext]
			& page_reg[zx_port_map_pkg::reg7_lock]);

	assign motor = page_reg_plus3[zx_port_map_pkg::reg1_motor];

	// Only the 1024K machines can reach pages above 7
	assert property (@(posedge clk_sys) disable iff (reset)
		!(p1024 || profi) |-> (page_128k == '0))
		else $error("Extended page set on a 128K-class model");

endmodule

`default_nettype wire

//--- zx_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module zx_addr_map (
	input wire logic [zx_mem_map_pkg::cpu_addr_w-1:0] addr,
	input wire logic mem_wr,
	input wire logic [zx_port_map_pkg::data_w-1:0] page_reg,
	input wire logic [zx_port_map_pkg::data_w-1:0] page_reg_plus3,
	input wire logic [zx_mem_map_pkg::ext_page_w-1:0] page_128k,
	input wire logic zx48,
	input wire logic plus3,
	output logic [zx_mem_map_pkg::ram_addr_w-1:0] ram_addr,
	output logic ram_we
);

	logic [zx_mem_map_pkg::bank_sel_w-1:0] bank;
	logic [zx_mem_map_pkg::bank_off_w-1:0] offset;
	logic [zx_mem_map_pkg::rom_page_w-1:0] rom_page;
	logic [zx_mem_map_pkg::ram_page_w-1:0] ram_page;
	logic [2:0] spec_page;
	logic special;
	logic spec_s;
	logic spec_t;
	logic rom_sel;

	assign bank = addr[zx_mem_map_pkg::cpu_addr_w-1:zx_mem_map_pkg::bank_off_w];
	assign offset = addr[zx_mem_map_pkg::bank_off_w-1:0];

	// All-RAM configurations of the +3
	assign special = page_reg_plus3[zx_port_map_pkg::reg1_special];
	assign spec_s = |page_reg_plus3[2:1];
	assign spec_t = &page_reg_plus3[2:1];

	// ==============================
	// ROM page
	// ==============================

	always_comb begin
		if (plus3) begin
			rom_page = {2'b10, page_reg_plus3[zx_port_map_pkg::reg1_rom],
				page_reg[zx_port_map_pkg::reg7_rom]};
		end else begin
			rom_page = {zx48, 2'b11, zx48 | page_reg[zx_port_map_pkg::reg7_rom]};
		end
	end

	// ==============================
	// Bank mapping
	// ==============================

	always_comb begin
		rom_sel = 1'b0;
		spec_page = '0;
		ram_page = '0;

		if (special) begin
			case (bank)
				2'd0: spec_page = {spec_s, 2'b00};
				2'd1: spec_page = {spec_s, spec_t, 1'b1};
				2'd2: spec_page = {spec_s, 2'b10};
				default: spec_page = {~page_reg_plus3[2] & page_reg_plus3[1], 2'b11};
			endcase
			ram_page = {{zx_mem_map_pkg::ext_page_w{1'b0}}, spec_page};
		end else begin
			case (bank)
				2'd0: rom_sel = 1'b1;
				2'd1: ram_page = {{zx_mem_map_pkg::ext_page_w{1'b0}},
					zx_mem_map_pkg::bank_screen0};
				2'd2: ram_page = {{zx_mem_map_pkg::ext_page_w{1'b0}},
					zx_mem_map_pkg::bank_fixed_8000};
				// Low three bits from 7FFD
				default: ram_page = {page_128k, page_reg[2:0]};
			endcase
		end

		ram_addr = '0;
		if (rom_sel) begin
			ram_addr[zx_mem_map_pkg::rom_span_w-1:0] =
				{zx_mem_map_pkg::rom_base, rom_page, offset};
		end else begin
			ram_addr[zx_mem_map_pkg::ram_span_w-1:0] = {ram_page, offset};
		end

		// Bank 0 is write protected unless it holds RAM
		ram_we = mem_wr & ~rom_sel;
	end

endmodule

`default_nettype wire

//--- zx_mem_pager.sv
`timescale 1ns/1ps
`default_nettype none

module zx_mem_pager (
	input wire logic clk_sys,
	input wire logic reset,
	input wire zx_mem_map_pkg::model_t model,
	input wire logic [zx_mem_map_pkg::cpu_addr_w-1:0] addr,
	input wire logic [zx_port_map_pkg::data_w-1:0] data_in,
	input wire logic io_wr,
	input wire logic mem_wr,
	output logic [zx_mem_map_pkg::ram_addr_w-1:0] ram_addr,
	output logic ram_we,
	output logic screen_page,
	output logic motor
);

	logic wr_7ffd;
	logic wr_1ffd;
	logic wr_eff7;
	logic wr_dffd;
	logic [zx_port_map_pkg::data_w-1:0] page_reg;
	logic [zx_port_map_pkg::data_w-1:0] page_reg_plus3;
	logic [zx_mem_map_pkg::ext_page_w-1:0] page_128k;
	logic zx48;
	logic plus3;
	logic p1024;
	logic profi;
	logic page_disable;

	// Port write strobes
	zx_port_decode port_decode_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.io_wr(io_wr),
		.addr(addr),
		.page_disable(page_disable),
		.plus3(plus3),
		.p1024(p1024),
		.profi(profi),
		.wr_7ffd(wr_7ffd),
		.wr_1ffd(wr_1ffd),
		.wr_eff7(wr_eff7),
		.wr_dffd(wr_dffd)
	);

	zx_page_regs page_regs_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.model(model),
		.data_in(data_in),
		.wr_7ffd(wr_7ffd),
		.wr_1ffd(wr_1ffd),
		.wr_eff7(wr_eff7),
		.wr_dffd(wr_dffd),
		.page_reg(page_reg),
		.page_reg_plus3(page_reg_plus3),
		.page_128k(page_128k),
		.zx48(zx48),
		.plus3(plus3),
		.p1024(p1024),
		.profi(profi),
		.page_disable(page_disable),
		.screen_page(screen_page),
		.motor(motor)
	);

	// Combinational CPU to RAM address path
	zx_addr_map addr_map_i (
		.addr(addr),
		.mem_wr(mem_wr),
		.page_reg(page_reg),
		.page_reg_plus3(page_reg_plus3),
		.page_128k(page_128k),
		.zx48(zx48),
		.plus3(plus3),
		.ram_addr(ram_addr),
		.ram_we(ram_we)
	);

endmodule

`default_nettype wire

//--- tb_pager_model.svh
`ifndef TB_PAGER_MODEL_SVH
`define TB_PAGER_MODEL_SVH

// ==============================
// Paging register model
// ==============================

zx_mem_map_pkg::model_t ref_model;
logic [7:0] ref_7ffd;
logic [7:0] ref_1ffd;
logic [7:0] ref_eff7;
// Page bits above the 7FFD bank number
logic [2:0] ref_ext;

function automatic void clear_registers(input zx_mem_map_pkg::model_t m);
	ref_model = m;
	ref_7ffd = 8'h00;
	ref_1ffd = 8'h00;
	ref_eff7 = 8'h00;
	ref_ext = 3'd0;
endfunction

// One CPU port write, applied on the first cycle of io_wr
function automatic void apply_port_write(input logic [15:0] a, input logic [7:0] d);
	logic locked;
	logic hit_7ffd;
	locked = (ref_model == zx_mem_map_pkg::model_48k)
		|| (ref_7ffd[5] && (ref_model != zx_mem_map_pkg::model_p1024 || ref_eff7[2]));
	hit_7ffd = !locked && !a[15] && !a[1]
		&& (a[14] || ref_model != zx_mem_map_pkg::model_plus3);
	if (hit_7ffd) begin
		if (ref_model == zx_mem_map_pkg::model_p1024 && !ref_eff7[2]) begin
			ref_ext = {d[5], d[7], d[6]};
		end
		ref_7ffd = d;
	end
	if (ref_model == zx_mem_map_pkg::model_plus3 && !locked && (a & 16'hf002) == 16'h1000) begin
		ref_1ffd = d;
	end
	if (ref_model == zx_mem_map_pkg::model_p1024 && (a & 16'hf008) == 16'he000) begin
		ref_eff7 = d;
	end
	if (ref_model == zx_mem_map_pkg::model_profi && a == 16'hdffd) begin
		ref_ext = d[2:0];
	end
endfunction

// ==============================
// Expected address and write enable
// ==============================

function automatic logic [24:0] expected_ram_addr(input logic [15:0] a);
	logic [5:0] page;
	logic [3:0] rom;
	logic hi;
	logic lo;
	hi = ref_1ffd[2];
	lo = ref_1ffd[1];
	// +3 all-RAM layouts
	if (ref_1ffd[0]) begin
		case (a[15:14])
			2'd0: page = {3'b000, hi | lo, 2'b00};
			2'd1: page = {3'b000, hi | lo, hi & lo, 1'b1};
			2'd2: page = {3'b000, hi | lo, 2'b10};
			default: page = {3'b000, !hi && lo, 2'b11};
		endcase
		return {5'd0, page, a[13:0]};
	end
	if (a[15:14] == 2'd0) begin
		if (ref_model == zx_mem_map_pkg::model_plus3) begin
			rom = {2'b10, hi, ref_7ffd[4]};
		end else if (ref_model == zx_mem_map_pkg::model_48k) begin
			rom = 4'b1111;
		end else begin
			rom = {3'b011, ref_7ffd[4]};
		end
		return {4'd0, 3'd5, rom, a[13:0]};
	end
	case (a[15:14])
		2'd1: page = 6'd5;
		2'd2: page = 6'd2;
		default: page = {ref_ext, ref_7ffd[2:0]};
	endcase
	return {5'd0, page, a[13:0]};
endfunction

function automatic logic expected_ram_we(input logic [15:0] a, input logic wr);
	return wr && (ref_1ffd[0] || a[15:14] != 2'd0);
endfunction

`endif

//--- tb_zx_mem_pager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_mem_pager;

	logic clk_sys;
	logic reset;
	zx_mem_map_pkg::model_t model;
	logic [15:0] addr;
	logic [7:0] data_in;
	logic io_wr;
	logic mem_wr;
	logic [24:0] ram_addr;
	logic ram_we;
	logic screen_page;
	logic motor;

	int error_count;
	int check_count;
	logic checks_on;
	logic io_wr_seen;
	logic [31:0] rng_state;

	`include "tb_pager_model.svh"

	zx_mem_pager dut_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.model(model),
		.addr(addr),
		.data_in(data_in),
		.io_wr(io_wr),
		.mem_wr(mem_wr),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.screen_page(screen_page),
		.motor(motor)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic void report_mismatch(input string name, input logic [24:0] got,
		input logic [24:0] exp);
		error_count++;
		$display("ERROR: %s got %h expected %h (addr %h)", name, got, exp, addr);
	endfunction

	// Model follows the same edges as the DUT registers
	always @(posedge clk_sys) begin
		if (reset) begin
			clear_registers(model);
			io_wr_seen = 1'b0;
		end else begin
			if (io_wr && !io_wr_seen) begin
				apply_port_write(addr, data_in);
			end
			io_wr_seen = io_wr;
		end
	end

	// ==============================
	// Output comparison
	// ==============================

	always @(negedge clk_sys) begin
		if (checks_on) begin
			check_count++;
			assert (ram_addr === expected_ram_addr(addr))
				else report_mismatch("ram_addr", ram_addr, expected_ram_addr(addr));
			assert (ram_we === expected_ram_we(addr, mem_wr))
				else report_mismatch("ram_we", ram_we, expected_ram_we(addr, mem_wr));
			assert (screen_page === ref_7ffd[3])
				else report_mismatch("screen_page", screen_page, ref_7ffd[3]);
			assert (motor === ref_1ffd[3])
				else report_mismatch("motor", motor, ref_1ffd[3]);
		end
	end

	task automatic apply_reset(input zx_mem_map_pkg::model_t m);
		int n;
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		io_wr <= 1'b0;
		mem_wr <= 1'b0;
		addr <= '0;
		checks_on = 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		// ROM must show at address 0 once out of reset
		n = 0;
		@(negedge clk_sys);
		while (ram_addr !== expected_ram_addr(addr) && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (ram_addr !== expected_ram_addr(addr)) begin
			$display("Timeout waiting for the address map to settle after reset");
			$display("STATUS: FAIL");
			$finish;
		end
	endtask

	// Later cycles of a held write carry other data
	task automatic port_write(input logic [15:0] a, input logic [7:0] d, input int cycles);
		@(posedge clk_sys);
		addr <= a;
		data_in <= d;
		io_wr <= 1'b1;
		mem_wr <= 1'b0;
		for (int i = 1; i < cycles; i++) begin
			@(posedge clk_sys);
			data_in <= ~d;
		end
		@(posedge clk_sys);
		io_wr <= 1'b0;
	endtask

	task automatic access_banks(input logic wr);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			r = next_rand();
			@(posedge clk_sys);
			addr <= {b[1:0], r[13:0]};
			mem_wr <= wr;
		end
		@(posedge clk_sys);
		mem_wr <= 1'b0;
	endtask

	task automatic random_traffic(input int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++) begin
			r = next_rand();
			@(posedge clk_sys);
			addr <= r[15:0];
			data_in <= r[23:16];
			io_wr <= r[24] & r[25];
			mem_wr <= r[26];
		end
		@(posedge clk_sys);
		io_wr <= 1'b0;
		mem_wr <= 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		clk_sys = 1'b0;
		reset = 1'b1;
		model = zx_mem_map_pkg::model_128k;
		addr = '0;
		data_in = '0;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		error_count = 0;
		check_count = 0;
		checks_on = 1'b0;
		io_wr_seen = 1'b0;
		rng_state = 32'h861f64ba;

		// 128K, random pages then the lock
		apply_reset(zx_mem_map_pkg::model_128k);
		access_banks(1'b1);
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			port_write(r[15:0] & 16'h7ffd, r[23:16] & 8'hdf, 1);
			access_banks(r[24]);
		end
		port_write(16'h7ffd, 8'h21, 1);
		port_write(16'h7ffd, 8'h16, 1);
		access_banks(1'b1);
		random_traffic(60);

		// Pentagon 1024 extension, then frozen by EFF7
		apply_reset(zx_mem_map_pkg::model_p1024);
		access_banks(1'b0);
		for (int i = 0; i < 6; i++) begin
			r = next_rand();
			port_write(r[15:0] & 16'h7ffd, r[23:16], 1);
			access_banks(1'b1);
		end
		port_write(16'heff7, 8'h04, 1);
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			port_write(16'h7ffd, r[23:16] & 8'hdf, 1);
			access_banks(1'b1);
		end
		port_write(16'h7ffd, 8'h20, 1);
		port_write(16'h7ffd, 8'h07, 1);
		random_traffic(60);

		// Profi, DFFD sets the upper page bits
		apply_reset(zx_mem_map_pkg::model_profi);
		access_banks(1'b0);
		for (int i = 0; i < 6; i++) begin
			r = next_rand();
			port_write(16'hdffd, r[7:0], 1);
			port_write(16'h7ffd, r[23:16] & 8'hdf, 1);
			access_banks(1'b1);
		end
		random_traffic(60);

		// 48K ignores every paging port
		apply_reset(zx_mem_map_pkg::model_48k);
		r = next_rand();
		port_write(16'h7ffd, r[7:0], 1);
		port_write(16'h1ffd, r[15:8], 1);
		port_write(16'heff7, r[23:16], 1);
		port_write(16'hdffd, r[31:24], 1);
		access_banks(1'b1);
		random_traffic(60);

		// +3, every special mode and ROM select
		apply_reset(zx_mem_map_pkg::model_plus3);
		access_banks(1'b1);
		for (int d = 0; d < 16; d++) begin
			r = next_rand();
			port_write(16'h1ffd, {r[7:4], d[3:0]}, 1);
			port_write(16'h7ffd, r[23:16] & 8'hdf, 1);
			port_write(16'h3ffd, r[31:24], 1);
			access_banks(1'b1);
		end
		random_traffic(100);

		// Held io_wr applies the first data only
		apply_reset(zx_mem_map_pkg::model_128k);
		port_write(16'h7ffd, 8'h05, 6);
		access_banks(1'b1);
		apply_reset(zx_mem_map_pkg::model_plus3);
		port_write(16'h1ffd, 8'h0d, 5);
		access_banks(1'b1);

		@(negedge clk_sys);
		checks_on = 1'b0;
		$display("Run complete: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
zx_mem_map_pkg.sv
zx_port_map_pkg.sv
zx_port_decode.sv
zx_page_regs.sv
zx_addr_map.sv
zx_mem_pager.sv
tb_zx_mem_pager.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_mem_pager -f list.f &&
{ ./obj_dir/Vtb_zx_mem_pager > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "STATUS: FAIL" sim.log &&
grep -q "STATUS: PASS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
